// ==== source/rv_exec_macros.svh ====
/*
 * Execute subsystem sizing constants
 */
`ifndef RV_EXEC_MACROS_SVH
`define RV_EXEC_MACROS_SVH

// Instruction queue entries, also the fetch agent's credits after reset
`define INSTR_Q_DEPTH 4

// Most retire credits the core can hold at once
`define RET_CREDIT_MAX 4

// Architectural integer registers
`define REG_COUNT 32

`endif

// ==== source/rv_isa_pkg.sv ====
/*
 * RV32I ISA-level types: words, register indexes, opcodes,
 * ALU operations and branch kinds
 */
package rv_isa_pkg;

    // Data and address word
    typedef logic [31:0] word_t;

    // Register index
    typedef logic [4:0] reg_idx_t;

    // Major opcodes handled by the subsystem
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011
    } opcode_t;

    // RV32I ALU operations
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_t;

    // Branch kinds, encoded as funct3
    typedef enum logic [2:0] {
        BR_BEQ  = 3'b000,
        BR_BNE  = 3'b001,
        BR_BLT  = 3'b100,
        BR_BGE  = 3'b101,
        BR_BLTU = 3'b110,
        BR_BGEU = 3'b111
    } branch_t;

endpackage

// ==== source/rv_pipe_pkg.sv ====
/*
 * Pipeline-level types: decoder control bundle and
 * execute-to-writeback record
 */
package rv_pipe_pkg;

    // ALU operand A source
    typedef enum logic [1:0] {A_RS1, A_PC, A_ZERO} alu_a_sel_t;

    // ALU operand B source
    typedef enum logic {B_RS2, B_IMM} alu_b_sel_t;

    // Decoder output
    typedef struct packed {
        rv_isa_pkg::reg_idx_t rs1;
        rv_isa_pkg::reg_idx_t rs2;
        rv_isa_pkg::reg_idx_t rd;
        alu_a_sel_t           a_sel;
        alu_b_sel_t           b_sel;
        rv_isa_pkg::alu_op_t  alu_op;
        rv_isa_pkg::word_t    imm;
        logic                 wen;
        logic                 jump;
        logic                 jump_reg;
        logic                 branch;
        rv_isa_pkg::branch_t  br_kind;
        logic                 illegal;
    } ctrl_t;

    // Execute-to-writeback record
    typedef struct packed {
        logic                 valid;
        rv_isa_pkg::word_t    pc;
        rv_isa_pkg::reg_idx_t rd;
        logic                 wen;
        rv_isa_pkg::word_t    result;
        rv_isa_pkg::word_t    next_pc;
        logic                 illegal;
    } ex_wb_t;

endpackage

// ==== source/rv_pipe_ifs.sv ====
/*
 * Internal links: queue head to execute, register file ports,
 * and execute-to-writeback record with its stall
 */
interface issue_if;
    import rv_isa_pkg::*;
    logic  valid;
    word_t pc;
    word_t instr;
    logic  pop;
    modport queue   (output valid, pc, instr, input pop);
    modport execute (input valid, pc, instr, output pop);
endinterface

interface reg_file_if;
    import rv_isa_pkg::*;
    reg_idx_t rs1, rs2, rd;
    word_t    rs1_data, rs2_data, wdata;
    logic     wen;
    modport rf        (input rs1, rs2, rd, wdata, wen, output rs1_data, rs2_data);
    modport execute   (output rs1, rs2, input rs1_data, rs2_data);
    modport writeback (output rd, wdata, wen);
endinterface

interface ex_wb_if;
    import rv_pipe_pkg::*;
    ex_wb_t rec;
    logic   stall;
    modport execute   (output rec, input stall);
    modport writeback (input rec, output stall);
endinterface

// ==== source/instr_queue.sv ====
/*
 * Instruction queue on the receiving end of the input credit link,
 * returns one credit for each entry popped
 */
`include "rv_exec_macros.svh"

module instr_queue (
    input  logic              CLK,
    input  logic              nRST,
    input  logic              in_valid,
    input  rv_isa_pkg::word_t in_pc,
    input  rv_isa_pkg::word_t in_instr,
    output logic              in_credit,
    issue_if.queue            issue
);
    import rv_isa_pkg::*;

    localparam int DEPTH = `INSTR_Q_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    word_t             pc_mem    [DEPTH];
    word_t             instr_mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr, rd_ptr;
    logic [CNT_W-1:0]  count;

    // Head entry
    assign issue.valid = (count != '0);
    assign issue.pc    = pc_mem[rd_ptr];
    assign issue.instr = instr_mem[rd_ptr];

    // Storage, space guaranteed by credits
    always_ff @(posedge CLK) begin
        if (in_valid) begin
            pc_mem[wr_ptr]    <= in_pc;
            instr_mem[wr_ptr] <= in_instr;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            in_credit <= 1'b0;
        end else begin
            // Credit back one cycle after each pop
            in_credit <= issue.pop;
            if (in_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (issue.pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Occupancy
            case ({in_valid, issue.pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== source/decoder.sv ====
/*
 * RV32I control unit, turns an instruction into the control bundle
 */
module decoder (
    input  rv_isa_pkg::word_t  instr,
    output rv_pipe_pkg::ctrl_t ctrl
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    // funct3 to ALU op, alt selects sub or sra
    function automatic alu_op_t alu_sel(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  alu_sel = alt ? ALU_SUB : ALU_ADD;
            3'b001:  alu_sel = ALU_SLL;
            3'b010:  alu_sel = ALU_SLT;
            3'b011:  alu_sel = ALU_SLTU;
            3'b100:  alu_sel = ALU_XOR;
            3'b101:  alu_sel = alt ? ALU_SRA : ALU_SRL;
            3'b110:  alu_sel = ALU_OR;
            default: alu_sel = ALU_AND;
        endcase
    endfunction

    opcode_t    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i, imm_b, imm_u, imm_j;

    assign opcode = opcode_t'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // Sign-extended immediates
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        ctrl         = '0;
        ctrl.rs1     = instr[19:15];
        ctrl.rs2     = instr[24:20];
        ctrl.rd      = instr[11:7];
        ctrl.a_sel   = A_ZERO;
        ctrl.b_sel   = B_IMM;
        ctrl.alu_op  = ALU_ADD;
        ctrl.br_kind = BR_BEQ;
        case (opcode)
            OPC_OP: begin
                ctrl.a_sel  = A_RS1;
                ctrl.b_sel  = B_RS2;
                ctrl.wen    = 1'b1;
                ctrl.alu_op = alu_sel(funct3, funct7[5]);
                // Only sub and sra take the alternate funct7
                if (funct7 == 7'b0100000) begin
                    ctrl.illegal = !(funct3 == 3'b000 || funct3 == 3'b101);
                end else if (funct7 != 7'b0) begin
                    ctrl.illegal = 1'b1;
                end
            end
            OPC_OP_IMM: begin
                ctrl.a_sel  = A_RS1;
                ctrl.imm    = imm_i;
                ctrl.wen    = 1'b1;
                ctrl.alu_op = alu_sel(funct3, funct3 == 3'b101 && funct7[5]);
                // Shift immediates restrict funct7
                if (funct3 == 3'b001) begin
                    ctrl.illegal = (funct7 != 7'b0);
                end else if (funct3 == 3'b101) begin
                    ctrl.illegal = (funct7 != 7'b0) && (funct7 != 7'b0100000);
                end
            end
            OPC_LUI: begin
                ctrl.imm = imm_u;
                ctrl.wen = 1'b1;
            end
            OPC_AUIPC: begin
                ctrl.a_sel = A_PC;
                ctrl.imm   = imm_u;
                ctrl.wen   = 1'b1;
            end
            OPC_JAL: begin
                ctrl.imm  = imm_j;
                ctrl.wen  = 1'b1;
                ctrl.jump = 1'b1;
            end
            OPC_JALR: begin
                ctrl.imm      = imm_i;
                ctrl.wen      = 1'b1;
                ctrl.jump_reg = 1'b1;
                ctrl.illegal  = (funct3 != 3'b000);
            end
            OPC_BRANCH: begin
                ctrl.imm     = imm_b;
                ctrl.branch  = 1'b1;
                ctrl.br_kind = branch_t'(funct3);
                ctrl.illegal = (funct3 == 3'b010) || (funct3 == 3'b011);
            end
            default: ctrl.illegal = 1'b1;
        endcase
        // Illegal ops retire as a zero result falling through to pc + 4
        if (ctrl.illegal) begin
            ctrl.a_sel    = A_ZERO;
            ctrl.b_sel    = B_IMM;
            ctrl.imm      = '0;
            ctrl.alu_op   = ALU_ADD;
            ctrl.wen      = 1'b0;
            ctrl.jump     = 1'b0;
            ctrl.jump_reg = 1'b0;
            ctrl.branch   = 1'b0;
        end
        // x0 is never written
        if (ctrl.rd == '0) begin
            ctrl.wen = 1'b0;
        end
    end

endmodule

// ==== source/reg_file.sv ====
/*
 * Integer register file, two combinational reads and one write,
 * x0 reads as zero
 */
`include "rv_exec_macros.svh"

module reg_file (
    input  logic   CLK,
    input  logic   nRST,
    reg_file_if.rf rf
);
    import rv_isa_pkg::*;

    word_t regs [`REG_COUNT];

    // Reads, x0 stays zero because it is never written
    assign rf.rs1_data = regs[rf.rs1];
    assign rf.rs2_data = regs[rf.rs2];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (rf.wen && rf.rd != '0) begin
            regs[rf.rd] <= rf.wdata;
        end
    end

endmodule

// ==== source/execute_stage.sv ====
/*
 * Execute stage: forwarding, operand select, ALU, jump and branch
 * resolution, and the execute-to-writeback register
 */
module execute_stage (
    input  logic               CLK,
    input  logic               nRST,
    issue_if.execute           issue,
    input  rv_pipe_pkg::ctrl_t ctrl,
    output rv_isa_pkg::word_t  instr,
    reg_file_if.execute        rf,
    ex_wb_if.execute           ex_wb
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    logic  fwd_rs1, fwd_rs2;
    word_t rs1_val, rs2_val;
    word_t op_a, op_b, alu_out;
    word_t pc4, result, next_pc;
    logic  taken;

    // Head instruction to the decoder
    assign instr = issue.instr;

    // Register indexes to the register file
    assign rf.rs1 = ctrl.rs1;
    assign rf.rs2 = ctrl.rs2;

    // Forward the retiring record's result
    assign fwd_rs1 = ex_wb.rec.valid && ex_wb.rec.wen && (ex_wb.rec.rd != '0)
                     && (ex_wb.rec.rd == ctrl.rs1);
    assign fwd_rs2 = ex_wb.rec.valid && ex_wb.rec.wen && (ex_wb.rec.rd != '0)
                     && (ex_wb.rec.rd == ctrl.rs2);
    assign rs1_val = fwd_rs1 ? ex_wb.rec.result : rf.rs1_data;
    assign rs2_val = fwd_rs2 ? ex_wb.rec.result : rf.rs2_data;

    // Operand A
    always_comb begin
        case (ctrl.a_sel)
            A_RS1:   op_a = rs1_val;
            A_PC:    op_a = issue.pc;
            default: op_a = '0;
        endcase
    end

    // Operand B
    assign op_b = (ctrl.b_sel == B_RS2) ? rs2_val : ctrl.imm;

    // ALU
    always_comb begin
        case (ctrl.alu_op)
            ALU_SUB:  alu_out = op_a - op_b;
            ALU_SLL:  alu_out = op_a << op_b[4:0];
            ALU_SLT:  alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_out = {31'b0, op_a < op_b};
            ALU_XOR:  alu_out = op_a ^ op_b;
            ALU_SRL:  alu_out = op_a >> op_b[4:0];
            ALU_SRA:  alu_out = $signed(op_a) >>> op_b[4:0];
            ALU_OR:   alu_out = op_a | op_b;
            ALU_AND:  alu_out = op_a & op_b;
            default:  alu_out = op_a + op_b;
        endcase
    end

    // Branch condition on forwarded operands
    always_comb begin
        case (ctrl.br_kind)
            BR_BEQ:  taken = (rs1_val == rs2_val);
            BR_BNE:  taken = (rs1_val != rs2_val);
            BR_BLT:  taken = ($signed(rs1_val) < $signed(rs2_val));
            BR_BGE:  taken = ($signed(rs1_val) >= $signed(rs2_val));
            BR_BLTU: taken = (rs1_val < rs2_val);
            BR_BGEU: taken = (rs1_val >= rs2_val);
            default: taken = 1'b0;
        endcase
    end

    // Next pc and link value
    assign pc4 = issue.pc + 32'd4;
    always_comb begin
        if (ctrl.jump_reg) begin
            next_pc = (rs1_val + ctrl.imm) & ~32'd1;
        end else if (ctrl.jump || (ctrl.branch && taken)) begin
            next_pc = issue.pc + ctrl.imm;
        end else begin
            next_pc = pc4;
        end
    end
    assign result = (ctrl.jump || ctrl.jump_reg) ? pc4 : alu_out;

    // Pop and capture together
    assign issue.pop = issue.valid && !ex_wb.stall;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            ex_wb.rec <= '0;
        end else if (!ex_wb.stall) begin
            // Empty queue loads a bubble
            ex_wb.rec.valid   <= issue.valid;
            ex_wb.rec.wen     <= issue.valid && ctrl.wen;
            ex_wb.rec.illegal <= issue.valid && ctrl.illegal;
            ex_wb.rec.pc      <= issue.pc;
            ex_wb.rec.rd      <= ctrl.rd;
            ex_wb.rec.result  <= result;
            ex_wb.rec.next_pc <= next_pc;
        end
    end

endmodule

// ==== source/writeback_stage.sv ====
/*
 * Writeback stage: retires the record against output credit,
 * writes the register file and raises stall when out of credit
 */
`include "rv_exec_macros.svh"

module writeback_stage (
    input  logic                 CLK,
    input  logic                 nRST,
    ex_wb_if.writeback           ex_wb,
    reg_file_if.writeback        rf,
    input  logic                 ret_credit,
    output logic                 ret_valid,
    output rv_isa_pkg::word_t    ret_pc,
    output rv_isa_pkg::word_t    ret_data,
    output rv_isa_pkg::word_t    ret_next_pc,
    output rv_isa_pkg::reg_idx_t ret_rd,
    output logic                 ret_wen,
    output logic                 ret_illegal
);
    import rv_isa_pkg::*;

    localparam int CRED_MAX = `RET_CREDIT_MAX;
    localparam int CRED_W   = $clog2(CRED_MAX + 1);

    logic [CRED_W-1:0] credit;
    logic              retire;

    // Retire while credit is available
    assign retire      = ex_wb.rec.valid && (credit != '0);
    assign ex_wb.stall = ex_wb.rec.valid && (credit == '0);

    // Retire report
    assign ret_valid   = retire;
    assign ret_pc      = ex_wb.rec.pc;
    assign ret_data    = ex_wb.rec.result;
    assign ret_next_pc = ex_wb.rec.next_pc;
    assign ret_rd      = ex_wb.rec.rd;
    assign ret_wen     = ex_wb.rec.wen;
    assign ret_illegal = ex_wb.rec.illegal;

    // Register write lands at the retiring edge
    assign rf.wen   = retire && ex_wb.rec.wen;
    assign rf.rd    = ex_wb.rec.rd;
    assign rf.wdata = ex_wb.rec.result;

    // Output credit, saturating at the limit
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            credit <= '0;
        end else begin
            case ({ret_credit, retire})
                2'b10: begin
                    if (credit != CRED_W'(CRED_MAX)) begin
                        credit <= credit + 1'b1;
                    end
                end
                2'b01:   credit <= credit - 1'b1;
                default: credit <= credit;
            endcase
        end
    end

endmodule

// ==== source/rv_exec_top.sv ====
/*
 * RV32I two-stage execute subsystem with credit links on
 * the instruction input and the retire output
 */
module rv_exec_top (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 in_valid,
    input  rv_isa_pkg::word_t    in_pc,
    input  rv_isa_pkg::word_t    in_instr,
    output logic                 in_credit,
    input  logic                 ret_credit,
    output logic                 ret_valid,
    output rv_isa_pkg::word_t    ret_pc,
    output rv_isa_pkg::reg_idx_t ret_rd,
    output logic                 ret_wen,
    output rv_isa_pkg::word_t    ret_data,
    output rv_isa_pkg::word_t    ret_next_pc,
    output logic                 ret_illegal
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    issue_if    issue ();
    reg_file_if rf ();
    ex_wb_if    ex_wb ();

    word_t instr;
    ctrl_t ctrl;

    instr_queue u_instr_queue (
        .CLK,
        .nRST,
        .in_valid,
        .in_pc,
        .in_instr,
        .in_credit,
        .issue (issue.queue)
    );

    decoder u_decoder (
        .instr,
        .ctrl
    );

    reg_file u_reg_file (
        .CLK,
        .nRST,
        .rf (rf.rf)
    );

    execute_stage u_execute_stage (
        .CLK,
        .nRST,
        .issue (issue.execute),
        .ctrl,
        .instr,
        .rf    (rf.execute),
        .ex_wb (ex_wb.execute)
    );

    writeback_stage u_writeback_stage (
        .CLK,
        .nRST,
        .ex_wb (ex_wb.writeback),
        .rf    (rf.writeback),
        .ret_credit,
        .ret_valid,
        .ret_pc,
        .ret_data,
        .ret_next_pc,
        .ret_rd,
        .ret_wen,
        .ret_illegal
    );

endmodule

// ==== verif/rv_exec_asserts.sv ====
/*
 * Concurrent checks on the execute subsystem's top-level ports
 */
module rv_exec_asserts (
    input logic                 CLK,
    input logic                 nRST,
    input logic                 in_valid,
    input logic                 in_credit,
    input logic                 ret_valid,
    input logic                 ret_wen,
    input logic                 ret_illegal,
    input rv_isa_pkg::reg_idx_t ret_rd
);
    timeunit 1ns;
    timeprecision 100ps;

    // Instructions received and not yet credited back
    int unsigned held;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            held <= 0;
        end else begin
            held <= held + 32'(in_valid) - 32'(in_credit);
        end
    end

    // Nothing retires in reset
    a_no_ret_in_reset: assert property (@(posedge CLK) !nRST |-> !ret_valid)
        else $error("ret_valid high while reset is active");

    a_illegal_no_wen: assert property (@(posedge CLK) disable iff (!nRST)
        ret_illegal |-> !ret_wen)
        else $error("ret_wen high on an illegal instruction");

    // x0 never written
    a_wen_rd_nonzero: assert property (@(posedge CLK) disable iff (!nRST)
        ret_wen |-> (ret_rd != '0))
        else $error("ret_wen high with ret_rd zero");

    // Each credit pulse needs a popped instruction behind it
    a_credit_per_pop: assert property (@(posedge CLK) disable iff (!nRST)
        in_credit |-> (held != 0))
        else $error("in_credit pulse with no instruction left to pop");

endmodule

bind rv_exec_top rv_exec_asserts u_rv_exec_asserts (
    .CLK         (CLK),
    .nRST        (nRST),
    .in_valid    (in_valid),
    .in_credit   (in_credit),
    .ret_valid   (ret_valid),
    .ret_wen     (ret_wen),
    .ret_illegal (ret_illegal),
    .ret_rd      (ret_rd)
);

// ==== verif/rv_exec_tb.sv ====
/*
 * Execute subsystem testbench: credit-honoring fetch agent, credit-granting
 * retire sink and an in-order reference model with its own registers
 */
`include "rv_exec_macros.svh"

module rv_exec_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import rv_isa_pkg::*;

    localparam int N_INSTR     = 400;
    localparam int RUN_LIMIT   = 20000;
    localparam int DRAIN_LIMIT = 2000;

    // Expected retire record
    typedef struct packed {
        word_t    pc;
        reg_idx_t rd;
        logic     wen;
        logic     has_data;
        word_t    data;
        word_t    next_pc;
        logic     illegal;
    } exp_t;

    logic     CLK, nRST;
    logic     in_valid, in_credit, ret_credit, ret_valid, ret_wen, ret_illegal;
    word_t    in_pc, in_instr, ret_pc, ret_data, ret_next_pc;
    reg_idx_t ret_rd;

    word_t mregs [`REG_COUNT];
    exp_t  exp_q [$];
    int    mismatches, failures, cycles;
    int    fetch_credit, sink_credit, sent, retired, credits_back;

    rv_exec_top u_rv_exec_top (
        .CLK         (CLK),
        .nRST        (nRST),
        .in_valid    (in_valid),
        .in_pc       (in_pc),
        .in_instr    (in_instr),
        .in_credit   (in_credit),
        .ret_credit  (ret_credit),
        .ret_valid   (ret_valid),
        .ret_pc      (ret_pc),
        .ret_rd      (ret_rd),
        .ret_wen     (ret_wen),
        .ret_data    (ret_data),
        .ret_next_pc (ret_next_pc),
        .ret_illegal (ret_illegal)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch %s: got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch %s: got 0x%02h expected 0x%02h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    // Mostly x1..x3 and x0, so dependencies come often
    function automatic reg_idx_t pick_reg();
        word_t r;
        r = $urandom;
        if (r[31:30] != 2'b00) begin
            return reg_idx_t'(r[1:0] + 2'd1);
        end
        return r[4:0];
    endfunction

    function automatic word_t gen_instr();
        word_t      w;
        int         kind;
        logic [6:0] opc, f7;
        logic [2:0] f3;
        w    = $urandom;
        kind = $urandom % 16;
        f3   = w[14:12];
        f7   = w[31:25];
        opc  = OPC_OP;
        case (kind)
            0, 1, 2, 3: begin
                f7 = (w[30] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
            end
            4, 5, 6: begin
                opc = OPC_OP_IMM;
                if (f3 == 3'd1) begin
                    f7 = 7'h00;
                end else if (f3 == 3'd5) begin
                    f7 = w[30] ? 7'h20 : 7'h00;
                end
            end
            7:  opc = OPC_LUI;
            8:  opc = OPC_AUIPC;
            9:  opc = OPC_JAL;
            10: begin
                opc = OPC_JALR;
                f3  = 3'd0;
            end
            11, 12, 13: begin
                opc = OPC_BRANCH;
                // Fold the two reserved funct3 codes onto legal kinds
                if (f3[2:1] == 2'b01) begin
                    f3[1] = 1'b0;
                end
            end
            14: begin
                // Bad funct on an otherwise supported opcode
                case ($urandom % 4)
                    0: f7 = 7'h01;
                    1: begin
                        opc = OPC_OP_IMM;
                        f3  = 3'd1;
                        f7  = 7'h20;
                    end
                    2: begin
                        opc = OPC_JALR;
                        f3  = 3'd1;
                    end
                    default: begin
                        opc = OPC_BRANCH;
                        f3  = 3'd2;
                    end
                endcase
            end
            default: begin
                // Load, store, system and fence opcodes are outside the subset
                case (w[1:0])
                    2'd0:    opc = 7'b0000011;
                    2'd1:    opc = 7'b0100011;
                    2'd2:    opc = 7'b1110011;
                    default: opc = 7'b0001111;
                endcase
            end
        endcase
        return {f7, pick_reg(), pick_reg(), f3, pick_reg(), opc};
    endfunction

    function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) begin
                    return word_t'($signed(a) >>> b[4:0]);
                end
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // Reference model, in program order against the model's registers
    task automatic predict(input word_t pc, input word_t ins, output exp_t e);
        logic [6:0] opc, f7;
        logic [2:0] f3;
        word_t      a, b, ii, ib, iu, ij;
        logic       legal, writes, taken;
        opc    = ins[6:0];
        f3     = ins[14:12];
        f7     = ins[31:25];
        a      = mregs[ins[19:15]];
        b      = mregs[ins[24:20]];
        ii     = {{20{ins[31]}}, ins[31:20]};
        ib     = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        iu     = {ins[31:12], 12'h000};
        ij     = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        e      = '0;
        e.pc   = pc;
        e.rd   = ins[11:7];
        e.next_pc = pc + 32'd4;
        legal  = 1'b1;
        writes = 1'b1;
        taken  = 1'b0;
        case (opc)
            OPC_OP: begin
                legal  = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
                e.data = alu_ref(f3, f7[5], a, b);
            end
            OPC_OP_IMM: begin
                if (f3 == 3'd1) begin
                    legal = (f7 == 7'h00);
                end else if (f3 == 3'd5) begin
                    legal = (f7 == 7'h00) || (f7 == 7'h20);
                end
                e.data = alu_ref(f3, f3 == 3'd5 && f7[5], a, ii);
            end
            OPC_LUI:   e.data = iu;
            OPC_AUIPC: e.data = pc + iu;
            OPC_JAL: begin
                e.data    = pc + 32'd4;
                e.next_pc = pc + ij;
            end
            OPC_JALR: begin
                legal     = (f3 == 3'd0);
                e.data    = pc + 32'd4;
                e.next_pc = (a + ii) & ~32'd1;
            end
            OPC_BRANCH: begin
                writes = 1'b0;
                legal  = !(f3 == 3'd2 || f3 == 3'd3);
                case (f3)
                    3'd0:    taken = (a == b);
                    3'd1:    taken = (a != b);
                    3'd4:    taken = ($signed(a) < $signed(b));
                    3'd5:    taken = ($signed(a) >= $signed(b));
                    3'd6:    taken = (a < b);
                    3'd7:    taken = (a >= b);
                    default: taken = 1'b0;
                endcase
                if (taken) begin
                    e.next_pc = pc + ib;
                end
            end
            default: legal = 1'b0;
        endcase
        if (!legal) begin
            e.illegal = 1'b1;
            e.next_pc = pc + 32'd4;
        end else begin
            e.has_data = writes;
            e.wen      = writes && (e.rd != '0);
            if (e.wen) begin
                mregs[e.rd] = e.data;
            end
        end
    endtask

    // One cycle: sample at the falling edge, then drive the next inputs
    task automatic step(input bit draining);
        exp_t  e;
        word_t pc, ins;
        int    grant_pct;
        @(negedge CLK);
        cycles++;
        if (in_credit) begin
            credits_back++;
            fetch_credit++;
            if (fetch_credit > `INSTR_Q_DEPTH) begin
                failures++;
                $display("Instruction credit returned beyond the queue depth at %0t", $time);
            end
        end
        if (ret_valid) begin
            if (sink_credit == 0) begin
                failures++;
                $display("Retirement without retire credit at %0t", $time);
            end else begin
                sink_credit--;
            end
            if (exp_q.size() == 0) begin
                failures++;
                $display("Retirement with no instruction outstanding at %0t", $time);
            end else begin
                e = exp_q.pop_front();
                retired++;
                check_word("ret_pc", ret_pc, e.pc);
                check_word("ret_next_pc", ret_next_pc, e.next_pc);
                check_reg("ret_rd", ret_rd, e.rd);
                check_flag("ret_wen", ret_wen, e.wen);
                check_flag("ret_illegal", ret_illegal, e.illegal);
                if (e.has_data) begin
                    check_word("ret_data", ret_data, e.data);
                end
            end
        end
        // Generous, stingy and withheld stretches of retire credit
        case ((cycles / 60) % 3)
            0:       grant_pct = 70;
            1:       grant_pct = 15;
            default: grant_pct = 0;
        endcase
        if (draining) begin
            grant_pct = 60;
        end
        ret_credit = 1'b0;
        if (sink_credit < `RET_CREDIT_MAX && ($urandom % 100) < grant_pct) begin
            ret_credit = 1'b1;
            sink_credit++;
        end
        in_valid = 1'b0;
        if (sent < N_INSTR && fetch_credit > 0 && ($urandom % 100) < 70) begin
            pc       = $urandom;
            pc[1:0]  = 2'b00;
            ins      = gen_instr();
            predict(pc, ins, e);
            exp_q.push_back(e);
            in_pc    = pc;
            in_instr = ins;
            in_valid = 1'b1;
            fetch_credit--;
            sent++;
        end
    endtask

    initial begin
        int t;
        void'($urandom(93239));
        nRST         = 1'b0;
        in_valid     = 1'b0;
        in_pc        = '0;
        in_instr     = '0;
        ret_credit   = 1'b0;
        mismatches   = 0;
        failures     = 0;
        cycles       = 0;
        fetch_credit = `INSTR_Q_DEPTH;
        sink_credit  = 0;
        sent         = 0;
        retired      = 0;
        credits_back = 0;
        for (int i = 0; i < `REG_COUNT; i++) begin
            mregs[i] = '0;
        end
        repeat (2) @(negedge CLK);
        nRST = 1'b1;

        t = 0;
        while (sent < N_INSTR && t < RUN_LIMIT) begin
            step(1'b0);
            t++;
        end
        if (sent < N_INSTR) begin
            failures++;
            $display("Timeout while sending, %0d of %0d instructions sent", sent, N_INSTR);
        end

        // Drain until every instruction retired and its credit came back
        t = 0;
        while ((retired < sent || credits_back < sent) && t < DRAIN_LIMIT) begin
            step(1'b1);
            t++;
        end
        if (retired < sent || credits_back < sent) begin
            failures++;
            $display("Timeout while draining, %0d retired and %0d credits back of %0d",
                     retired, credits_back, sent);
        end
        // Idle cycles catch late duplicates
        repeat (10) step(1'b1);
        if (credits_back != sent) begin
            failures++;
            $display("Instruction credits returned %0d differ from %0d sent",
                     credits_back, sent);
        end

        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== rv_exec_top.f ====
+incdir+source
source/rv_isa_pkg.sv
source/rv_pipe_pkg.sv
source/rv_pipe_ifs.sv
source/instr_queue.sv
source/decoder.sv
source/reg_file.sv
source/execute_stage.sv
source/writeback_stage.sv
source/rv_exec_top.sv
verif/rv_exec_asserts.sv
verif/rv_exec_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the execute subsystem testbench with Verilator and run it
rm -f sim.log && \
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module rv_exec_tb -f rv_exec_top.f -o rv_exec_sim && \
./obj_dir/rv_exec_sim > sim.log 2>&1
status=$?
cat sim.log 2>/dev/null
[ "$status" -eq 0 ] && ! grep -q "Finished with errors" sim.log && exit 0 || exit 1
